/* src.f */
common/ex_pkg.sv
alu_tmr/alu_lane.sv
alu_tmr/majority_voter.sv
alu_tmr/fault_monitor.sv
alu_tmr/alu_tmr.sv
hw/ex_wb_reg.sv
hw/ex_stage.sv
verification/ex_stage_properties.sv
verification/tb_ex_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ex_stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_ex_stage \
  -f src.f -o sim_ex_stage
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_ex_stage +verilator+error+limit+100 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* verification/tb_ex_stage.sv */
// directed testbench for the fault-tolerant execute stage
// reference alu model, expected fault counters, timeout

module tb_ex_stage;
  timeunit 1ns;
  timeprecision 100ps;

  // summed length of reset, monitor reads and all tests in cycles
  localparam int TEST_CYCLES    = 150;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                     clk;
  logic                     rst_n;
  logic                     req_valid_i;
  ex_pkg::ex_req_t          req_i;
  logic                     req_ready_o;
  ex_pkg::fault_mask_t      fault_mask_i;
  logic [1:0]               cnt_sel_i;
  logic [ex_pkg::CNT_W-1:0] cnt_rdata_o;
  ex_pkg::lane_vec_t        perm_faulty_o;
  logic                     wb_valid_o;
  ex_pkg::wb_t              wb_o;
  logic                     wb_ready_i;
  int                       cycle_cnt = 0;
  // expected monitor state
  logic [ex_pkg::CNT_W-1:0] exp_cnt [ex_pkg::NUM_LANES];
  ex_pkg::lane_vec_t        exp_perm;

  ex_stage i_ex_stage (.*);

  bind ex_stage ex_stage_properties i_ex_stage_properties (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .req_ready_o   ( req_ready_o   ),
    .wb_valid_o    ( wb_valid_o    ),
    .wb_ready_i    ( wb_ready_i    ),
    .wb_o          ( wb_o          ),
    .perm_faulty_o ( perm_faulty_o )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout, run still busy after %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $fatal(1, "timeout");
    end
  end

  // any bound assertion that has fired so far
  function automatic logic bound_assert_failed();
    return i_ex_stage.i_ex_stage_properties.hold_err
        || i_ex_stage.i_ex_stage_properties.ready_err
        || i_ex_stage.i_ex_stage_properties.perm_err;
  endfunction

  // assertions fire on the rising edge and stop the run at the next falling edge
  always @(negedge clk) begin
    if (bound_assert_failed()) begin
      $display("a bound assertion on ex_stage reported a violation");
      $display("Something failed");
      $fatal(1, "assertion violation");
    end
  end

  //////////////////////////////////////////////////
  // reference model and checks
  //////////////////////////////////////////////////

  function automatic logic [ex_pkg::DATA_W-1:0] ref_alu(input ex_pkg::alu_op_e op,
      input logic [ex_pkg::DATA_W-1:0] a, input logic [ex_pkg::DATA_W-1:0] b);
    logic [4:0]                sh;
    logic [ex_pkg::DATA_W-1:0] fill;
    logic                      lt;
    sh   = b[4:0];
    // sign fill for the arithmetic shift
    fill = a[ex_pkg::DATA_W-1] ? ~({ex_pkg::DATA_W{1'b1}} >> sh) : '0;
    // signed compare by sign bits first and by magnitude when signs agree
    lt   = (a[ex_pkg::DATA_W-1] != b[ex_pkg::DATA_W-1]) ? a[ex_pkg::DATA_W-1] : (a < b);
    case (op)
      ex_pkg::ALU_ADD:  return a + b;
      ex_pkg::ALU_SUB:  return a + ~b + 1'b1;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_SLL:  return a << sh;
      ex_pkg::ALU_SRL:  return a >> sh;
      ex_pkg::ALU_SRA:  return (a >> sh) | fill;
      ex_pkg::ALU_SLT:  return {{(ex_pkg::DATA_W-1){1'b0}}, lt};
      ex_pkg::ALU_SLTU: return {{(ex_pkg::DATA_W-1){1'b0}}, a < b};
      default:          return '0;
    endcase
  endfunction

  // lanes with a nonzero mask
  // masks stay pairwise disjoint so the vote always restores the true result
  function automatic ex_pkg::lane_vec_t lane_faulted(input ex_pkg::fault_mask_t mask);
    return {|mask.lane2, |mask.lane1, |mask.lane0};
  endfunction

  function automatic ex_pkg::wb_t expect_wb(input ex_pkg::ex_req_t req,
      input ex_pkg::fault_mask_t mask);
    ex_pkg::wb_t exp;
    exp.wdata         = ref_alu(req.op, req.operand_a, req.operand_b);
    exp.waddr         = req.waddr;
    exp.we            = req.we;
    exp.err_corrected = ($countones(lane_faulted(mask)) == 1);
    exp.err_multi     = ($countones(lane_faulted(mask)) >= 2);
    return exp;
  endfunction

  function automatic ex_pkg::ex_req_t rand_req(input ex_pkg::alu_op_e op);
    ex_pkg::ex_req_t req;
    logic [31:0]     r;
    r             = $urandom;
    req.op        = op;
    req.operand_a = $urandom;
    req.operand_b = $urandom;
    req.waddr     = r[ex_pkg::REG_ADDR_W-1:0];
    req.we        = r[31];
    return req;
  endfunction

  task automatic fail_now(input string msg);
    $display("[FAIL] %0d ns: %s", $time, msg);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_wb(input ex_pkg::wb_t got, input ex_pkg::wb_t exp, input string what);
    if (got !== exp) fail_now($sformatf("%s: wb_o %h, expected %h", what, got, exp));
  endtask

  task automatic compare_cnt(input logic [ex_pkg::CNT_W-1:0] got,
      input logic [ex_pkg::CNT_W-1:0] exp, input string what);
    if (got !== exp) fail_now($sformatf("%s: counter %0d, expected %0d", what, got, exp));
  endtask

  task automatic compare_lanes(input ex_pkg::lane_vec_t got, input ex_pkg::lane_vec_t exp,
      input string what);
    if (got !== exp) fail_now($sformatf("%s: perm flags %b, expected %b", what, got, exp));
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) fail_now($sformatf("%s: got %b, expected %b", what, got, exp));
  endtask

  //////////////////////////////////////////////////
  // drivers
  //////////////////////////////////////////////////

  // entered and left 1 ns after a rising edge
  task automatic send(input ex_pkg::ex_req_t req, input ex_pkg::fault_mask_t mask,
      input logic [1:0] sel);
    req_valid_i  = 1'b1;
    req_i        = req;
    fault_mask_i = mask;
    cnt_sel_i    = sel;
    @(negedge clk);
    while (!req_ready_o) @(negedge clk);
    @(posedge clk);
    #1;
    req_valid_i  = 1'b0;
    fault_mask_i = '0;
  endtask

  // one request with result and monitor checked one cycle after accept
  task automatic exec_check(input ex_pkg::ex_req_t req, input ex_pkg::fault_mask_t mask,
      input logic [1:0] sel, input string what);
    ex_pkg::lane_vec_t hit;
    hit = lane_faulted(mask);
    send(req, mask, sel);
    @(negedge clk);
    compare_bit(wb_valid_o, 1'b1, {what, " valid"});
    compare_wb(wb_o, expect_wb(req, mask), what);
    for (int i = 0; i < ex_pkg::NUM_LANES; i++) begin
      if (hit[i] && exp_cnt[i] != 4'd15) exp_cnt[i] = exp_cnt[i] + 1'b1;
      exp_perm[i] = exp_perm[i] | (exp_cnt[i] >= ex_pkg::FAULT_LIMIT);
    end
    compare_cnt(cnt_rdata_o, exp_cnt[sel], what);
    compare_lanes(perm_faulty_o, exp_perm, what);
    @(posedge clk);
    #1;
  endtask

  // reads every select value and expects zero for select 3 past the last lane
  task automatic check_monitor(input string what);
    for (int s = 0; s < 4; s++) begin
      cnt_sel_i = s[1:0];
      @(negedge clk);
      compare_cnt(cnt_rdata_o, (s < ex_pkg::NUM_LANES) ? exp_cnt[s] : '0, what);
      compare_lanes(perm_faulty_o, exp_perm, what);
      @(posedge clk);
      #1;
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_fault_free();
    ex_pkg::alu_op_e op;
    op = op.first();
    do begin
      repeat (4) exec_check(rand_req(op), '0, 2'd0, $sformatf("fault-free %s", op.name()));
      op = op.next();
    end while (op != op.first());
  endtask

  task automatic test_single_fault();
    ex_pkg::fault_mask_t mask;
    mask       = '0;
    mask.lane1 = $urandom | 32'h1;
    repeat (3) exec_check(rand_req(ex_pkg::ALU_SUB), mask, 2'd1, "single-lane fault");
  endtask

  task automatic test_dual_fault();
    ex_pkg::fault_mask_t mask;
    mask       = '0;
    // low and high halves never overlap
    mask.lane0 = ($urandom & 32'h0000_ffff) | 32'h0000_0001;
    mask.lane2 = ($urandom & 32'hffff_0000) | 32'h0001_0000;
    exec_check(rand_req(ex_pkg::ALU_OR), mask, 2'd0, "dual fault lane 0");
    exec_check(rand_req(ex_pkg::ALU_SLL), mask, 2'd2, "dual fault lane 2");
    check_monitor("after dual fault");
  endtask

  task automatic test_perm_fault();
    ex_pkg::fault_mask_t mask;
    mask       = '0;
    mask.lane1 = 32'h8000_0100;
    // enough requests to pass the limit and reach saturation
    repeat (14) exec_check(rand_req(ex_pkg::ALU_SRA), mask, 2'd1, "permanent fault");
    compare_cnt(cnt_rdata_o, 4'd15, "lane 1 counter saturated");
    compare_bit(perm_faulty_o[1], 1'b1, "lane 1 perm flag");
  endtask

  task automatic test_backpressure();
    ex_pkg::ex_req_t a;
    ex_pkg::ex_req_t b;
    ex_pkg::ex_req_t c;
    a = rand_req(ex_pkg::ALU_ADD);
    b = rand_req(ex_pkg::ALU_XOR);
    c = rand_req(ex_pkg::ALU_SLTU);
    wb_ready_i = 1'b0;
    send(a, '0, 2'd0);
    req_valid_i = 1'b1;
    req_i       = b;
    repeat (3) begin
      @(negedge clk);
      compare_bit(wb_valid_o, 1'b1, "stalled entry valid");
      compare_bit(req_ready_o, 1'b0, "req_ready_o under back-pressure");
      compare_wb(wb_o, expect_wb(a, '0), "stalled entry");
      @(posedge clk);
      #1;
    end
    wb_ready_i = 1'b1;
    @(negedge clk);
    compare_bit(req_ready_o, 1'b1, "req_ready_o after release");
    compare_wb(wb_o, expect_wb(a, '0), "drain first");
    @(posedge clk);
    #1;
    req_i = c;
    @(negedge clk);
    compare_bit(wb_valid_o, 1'b1, "drain second valid");
    compare_wb(wb_o, expect_wb(b, '0), "drain second");
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
    @(negedge clk);
    compare_bit(wb_valid_o, 1'b1, "drain third valid");
    compare_wb(wb_o, expect_wb(c, '0), "drain third");
    @(posedge clk);
    #1;
    @(negedge clk);
    compare_bit(wb_valid_o, 1'b0, "no duplicate after drain");
    @(posedge clk);
    #1;
  endtask

  initial begin
    void'($urandom(32'h6db3cfe5));
    rst_n        = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    fault_mask_i = '0;
    cnt_sel_i    = 2'd0;
    wb_ready_i   = 1'b1;
    exp_perm     = '0;
    for (int i = 0; i < ex_pkg::NUM_LANES; i++) exp_cnt[i] = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    compare_bit(wb_valid_o, 1'b0, "wb_valid_o after reset");
    check_monitor("after reset");
    test_fault_free();
    test_single_fault();
    test_dual_fault();
    test_perm_fault();
    test_backpressure();
    check_monitor("end of run");
    if (bound_assert_failed()) begin
      $display("a bound assertion on ex_stage reported a violation");
      $display("Something failed");
      $fatal(1, "assertion violation");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

/* verification/ex_stage_properties.sv */
// concurrent checks on the ex_stage handshake and fault flags
// bound into ex_stage by the testbench

module ex_stage_properties (
  input logic              clk,
  input logic              rst_n,
  input logic              req_ready_o,
  input logic              wb_valid_o,
  input logic              wb_ready_i,
  input ex_pkg::wb_t       wb_o,
  input ex_pkg::lane_vec_t perm_faulty_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // violation flags, read by the testbench when the run ends
  logic hold_err  = 1'b0;
  logic ready_err = 1'b0;
  logic perm_err  = 1'b0;

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // stalled entry keeps its valid and payload
  a_hold_under_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_o))
    else begin
      hold_err = 1'b1;
      $error("write-back entry changed while stalled");
    end

  // an empty register always takes a request
  a_ready_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_valid_o |-> req_ready_o)
    else begin
      ready_err = 1'b1;
      $error("req_ready_o low with empty write-back register");
    end

  //////////////////////////////////////////////////
  // sticky fault flags
  //////////////////////////////////////////////////

  a_perm_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    ($past(perm_faulty_o) & ~perm_faulty_o) == '0)
    else begin
      perm_err = 1'b1;
      $error("perm_faulty_o bit fell without reset");
    end

endmodule

/* hw/ex_stage.sv */
// fault-tolerant execute stage top level
// triple-redundant alu feeding the ex/wb register
// fault summary flags and monitor read-out

module ex_stage (
  input  logic                        clk,
  input  logic                        rst_n,
  // request side
  input  logic                        req_valid_i,
  input  ex_pkg::ex_req_t             req_i,
  output logic                        req_ready_o,
  // fault injection and monitor access
  input  ex_pkg::fault_mask_t         fault_mask_i,
  input  logic [1:0]                  cnt_sel_i,
  output logic [ex_pkg::CNT_W-1:0]    cnt_rdata_o,
  output ex_pkg::lane_vec_t           perm_faulty_o,
  // write-back side
  output logic                        wb_valid_o,
  output ex_pkg::wb_t                 wb_o,
  input  logic                        wb_ready_i
);

  // request handshake completes this cycle
  logic                      accept;
  // voted alu result
  logic [ex_pkg::DATA_W-1:0] alu_result;
  // lanes outvoted on the current request
  ex_pkg::lane_vec_t         mismatch;
  // number of outvoted lanes
  int unsigned               n_mismatch;
  // entry towards the pipeline register
  ex_pkg::wb_t               wb_d;

  // single accept strobe for both the register load and the counters
  assign accept = req_valid_i && req_ready_o;

  //////////////////////////////////////////////////
  // redundant alu
  //////////////////////////////////////////////////

  alu_tmr i_alu_tmr (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .req_i         ( req_i         ),
    .fault_mask_i  ( fault_mask_i  ),
    .count_en_i    ( accept        ),
    .cnt_sel_i     ( cnt_sel_i     ),
    .result_o      ( alu_result    ),
    .mismatch_o    ( mismatch      ),
    .cnt_rdata_o   ( cnt_rdata_o   ),
    .perm_faulty_o ( perm_faulty_o )
  );

  //////////////////////////////////////////////////
  // write-back entry
  //////////////////////////////////////////////////

  assign n_mismatch = $countones(mismatch);

  always_comb begin
    wb_d.wdata         = alu_result;
    wb_d.waddr         = req_i.waddr;
    wb_d.we            = req_i.we;
    // one outvoted lane is masked by the vote
    wb_d.err_corrected = (n_mismatch == 1);
    // more than one disagreement, vote may still hold on disjoint bits
    wb_d.err_multi     = (n_mismatch >= 2);
  end

  // result visible on wb_o one cycle after accept
  ex_wb_reg i_ex_wb_reg (
    .clk        ( clk         ),
    .rst_n      ( rst_n       ),
    .load_i     ( accept      ),
    .wb_i       ( wb_d        ),
    .wb_ready_i ( wb_ready_i  ),
    .wb_valid_o ( wb_valid_o  ),
    .wb_o       ( wb_o        ),
    .ready_o    ( req_ready_o )
  );

endmodule

/* hw/ex_wb_reg.sv */
// ex/wb pipeline register
// single entry with valid/ready handshake on both sides

module ex_wb_reg (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        load_i,
  input  ex_pkg::wb_t wb_i,
  input  logic        wb_ready_i,
  output logic        wb_valid_o,
  output ex_pkg::wb_t wb_o,
  output logic        ready_o
);

  // entry occupied
  logic        valid_q;
  // held write-back entry
  ex_pkg::wb_t wb_q;

  //////////////////////////////////////////////////
  // valid tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      if (load_i) begin
        // new entry, also covers take and refill on the same edge
        valid_q <= 1'b1;
      end else if (wb_ready_i) begin
        // downstream took the entry and nothing replaced it
        valid_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // load is only asserted while ready_o is high
    // so a stalled entry is never overwritten
    if (load_i) begin
      wb_q <= wb_i;
    end
  end

  // free slot, or the current entry leaves this cycle
  assign ready_o    = !valid_q || wb_ready_i;
  assign wb_valid_o = valid_q;
  assign wb_o       = wb_q;

endmodule

/* alu_tmr/alu_tmr.sv */
// triple-redundant alu block
// three lanes with their own fault masks, a voter and a fault monitor

module alu_tmr (
  input  logic                        clk,
  input  logic                        rst_n,
  input  ex_pkg::ex_req_t             req_i,
  input  ex_pkg::fault_mask_t         fault_mask_i,
  input  logic                        count_en_i,
  input  logic [1:0]                  cnt_sel_i,
  output logic [ex_pkg::DATA_W-1:0]   result_o,
  output ex_pkg::lane_vec_t           mismatch_o,
  output logic [ex_pkg::CNT_W-1:0]    cnt_rdata_o,
  output ex_pkg::lane_vec_t           perm_faulty_o
);

  // masks unpacked into an indexable array, lane 0 lowest
  logic [ex_pkg::NUM_LANES-1:0][ex_pkg::DATA_W-1:0] lane_mask;
  // raw lane outputs into the voter
  logic [ex_pkg::NUM_LANES-1:0][ex_pkg::DATA_W-1:0] lane_result;

  assign lane_mask = {fault_mask_i.lane2, fault_mask_i.lane1, fault_mask_i.lane0};

  //////////////////////////////////////////////////
  // redundant lanes
  //////////////////////////////////////////////////

  // same operation and operands fanned out to every lane
  for (genvar i = 0; i < ex_pkg::NUM_LANES; i++) begin : g_lane
    alu_lane i_alu_lane (
      .op_i         ( req_i.op         ),
      .a_i          ( req_i.operand_a  ),
      .b_i          ( req_i.operand_b  ),
      .fault_mask_i ( lane_mask[i]     ),
      .result_o     ( lane_result[i]   )
    );
  end

  //////////////////////////////////////////////////
  // vote and bookkeeping
  //////////////////////////////////////////////////

  majority_voter i_majority_voter (
    .lane_result_i ( lane_result ),
    .voted_o       ( result_o    ),
    .mismatch_o    ( mismatch_o  )
  );

  // counts disagreements only on accepted requests
  fault_monitor i_fault_monitor (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .count_en_i    ( count_en_i    ),
    .mismatch_i    ( mismatch_o    ),
    .cnt_sel_i     ( cnt_sel_i     ),
    .cnt_rdata_o   ( cnt_rdata_o   ),
    .perm_faulty_o ( perm_faulty_o )
  );

endmodule

/* alu_tmr/fault_monitor.sv */
// per-lane saturating mismatch counters
// sticky permanent-fault flags at the fault limit
// combinational counter read port

module fault_monitor (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            count_en_i,
  input  ex_pkg::lane_vec_t               mismatch_i,
  input  logic [1:0]                      cnt_sel_i,
  output logic [ex_pkg::CNT_W-1:0]        cnt_rdata_o,
  output ex_pkg::lane_vec_t               perm_faulty_o
);

  // current and next counter values, one per lane
  logic [ex_pkg::NUM_LANES-1:0][ex_pkg::CNT_W-1:0] cnt_q;
  logic [ex_pkg::NUM_LANES-1:0][ex_pkg::CNT_W-1:0] cnt_d;
  // sticky fault flags
  ex_pkg::lane_vec_t                               perm_q;
  ex_pkg::lane_vec_t                               perm_d;

  //////////////////////////////////////////////////
  // next-state logic
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < ex_pkg::NUM_LANES; i++) begin
      cnt_d[i] = cnt_q[i];
      // count only accepted requests on which this lane was outvoted
      // and stop at all ones
      if (count_en_i && mismatch_i[i] && !(&cnt_q[i])) begin
        cnt_d[i] = cnt_q[i] + 1'b1;
      end
      // flag follows the next count so it rises on the same edge
      perm_d[i] = perm_q[i] | (cnt_d[i] >= ex_pkg::FAULT_LIMIT);
    end
  end

  //////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      perm_q <= '0;
    end else begin
      cnt_q  <= cnt_d;
      perm_q <= perm_d;
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////

  always_comb begin
    cnt_rdata_o = '0;
    // select values past the last lane read as zero
    if (int'(cnt_sel_i) < ex_pkg::NUM_LANES) begin
      cnt_rdata_o = cnt_q[cnt_sel_i];
    end
  end

  assign perm_faulty_o = perm_q;

endmodule

/* alu_tmr/majority_voter.sv */
// bitwise 2-of-3 majority vote over the lane results
// per-lane flags for words that differ from the vote

module majority_voter (
  input  logic [ex_pkg::NUM_LANES-1:0][ex_pkg::DATA_W-1:0] lane_result_i,
  output logic [ex_pkg::DATA_W-1:0]                        voted_o,
  output ex_pkg::lane_vec_t                                mismatch_o
);

  //////////////////////////////////////////////////
  // majority per bit
  //////////////////////////////////////////////////

  // a bit is set when at least two lanes agree on a one
  assign voted_o = (lane_result_i[0] & lane_result_i[1])
                 | (lane_result_i[0] & lane_result_i[2])
                 | (lane_result_i[1] & lane_result_i[2]);

  //////////////////////////////////////////////////
  // disagreement flags
  //////////////////////////////////////////////////

  // each lane is compared against the voted word, not against its peers
  // so two lanes faulted on disjoint bits are both flagged
  for (genvar i = 0; i < ex_pkg::NUM_LANES; i++) begin : g_mismatch
    logic [ex_pkg::DATA_W-1:0] diff;

    // bit positions where this lane lost the vote
    assign diff          = lane_result_i[i] ^ voted_o;
    assign mismatch_o[i] = |diff;
  end

endmodule

/* alu_tmr/alu_lane.sv */
// single combinational alu lane
// add/sub, logic ops, shifts and set-less-than
// result xored with a per-lane fault-injection mask

module alu_lane (
  input  ex_pkg::alu_op_e             op_i,
  input  logic [ex_pkg::DATA_W-1:0]   a_i,
  input  logic [ex_pkg::DATA_W-1:0]   b_i,
  input  logic [ex_pkg::DATA_W-1:0]   fault_mask_i,
  output logic [ex_pkg::DATA_W-1:0]   result_o
);

  // raw result before fault injection
  logic [ex_pkg::DATA_W-1:0] alu_res;
  // shift amount, low five bits of operand b
  logic [4:0]                shamt;

  assign shamt = b_i[4:0];

  //////////////////////////////////////////////////
  // operation decode
  //////////////////////////////////////////////////

  always_comb begin
    alu_res = '0;
    case (op_i)
      ex_pkg::ALU_ADD: alu_res = a_i + b_i;
      ex_pkg::ALU_SUB: alu_res = a_i - b_i;
      ex_pkg::ALU_AND: alu_res = a_i & b_i;
      ex_pkg::ALU_OR:  alu_res = a_i | b_i;
      ex_pkg::ALU_XOR: alu_res = a_i ^ b_i;
      ex_pkg::ALU_SLL: alu_res = a_i << shamt;
      ex_pkg::ALU_SRL: alu_res = a_i >> shamt;
      // arithmetic shift keeps the sign bit
      ex_pkg::ALU_SRA: alu_res = $signed(a_i) >>> shamt;
      // compare results land in bit 0, upper bits stay zero
      ex_pkg::ALU_SLT: begin
        alu_res[0] = $signed(a_i) < $signed(b_i);
      end
      ex_pkg::ALU_SLTU: begin
        alu_res[0] = a_i < b_i;
      end
      // unused codes give zero
      default: alu_res = '0;
    endcase
  end

  // fault injection point, a zero mask leaves the result untouched
  assign result_o = alu_res ^ fault_mask_i;

endmodule

/* common/ex_pkg.sv */
// shared definitions for the fault-tolerant execute stage
// widths, lane count and fault limits
// alu operation codes
// request, fault-mask and write-back structs

package ex_pkg;

  //////////////////////////////////////////////////
  // widths and limits
  //////////////////////////////////////////////////

  // operand and result width
  localparam int DATA_W = 32;
  // register file address width
  localparam int REG_ADDR_W = 5;
  // redundant alu lanes behind the voter
  localparam int NUM_LANES = 3;
  // per-lane mismatch counter width, saturates at all ones
  localparam int CNT_W = 4;
  // count at which a lane is taken as permanently faulty
  localparam logic [CNT_W-1:0] FAULT_LIMIT = 4'd4;

  //////////////////////////////////////////////////
  // alu operations
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9
  } alu_op_e;

  //////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////

  // one bit per redundant lane
  typedef logic [NUM_LANES-1:0] lane_vec_t;

  // request from the decode side
  typedef struct packed {
    alu_op_e               op;
    logic [DATA_W-1:0]     operand_a;
    logic [DATA_W-1:0]     operand_b;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  we;
  } ex_req_t;

  // xor masks applied to each lane result, all zero in normal use
  typedef struct packed {
    logic [DATA_W-1:0] lane2;
    logic [DATA_W-1:0] lane1;
    logic [DATA_W-1:0] lane0;
  } fault_mask_t;

  // write-back entry towards the register file
  typedef struct packed {
    logic [DATA_W-1:0]     wdata;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  we;
    // exactly one lane outvoted
    logic                  err_corrected;
    // two or more lanes disagreed with the vote
    logic                  err_multi;
  } wb_t;

endpackage
